/* design/tetris_macros.svh */
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// Playfield size, row 0 is the top row
`define TETRIS_ROWS 22
`define TETRIS_COLS 10

// Pieces in the fixed spawn rotation
`define TETRIS_SHAPES 7

// Leftmost column of the 4-wide spawn box
`define TETRIS_SPAWN_COL 3

`endif

/* design/tetris_grid_pkg.sv */
`include "tetris_macros.svh"

package tetris_grid_pkg;

    // One row of cells, bit c is column c
    typedef logic [`TETRIS_COLS-1:0] row_t;

    // Full playfield bitmap
    // Index r is row r, row 0 at the top and row ROWS-1 on the floor
    typedef row_t [`TETRIS_ROWS-1:0] grid_t;

endpackage

/* design/tetris_ctrl_pkg.sv */
package tetris_ctrl_pkg;

    // Game controller states
    typedef enum logic [2:0] {
        SPAWN,      // Request next spawn bitmap
        SPAWN_WAIT, // Bitmap ready, top-out check
        FALLING,    // Piece steps down on drop ticks
        LANDED,     // Merge piece into stored grid
        GAME_OVER   // Top-out, held until reset
    } game_state_t;

    // Spawn order follows the encoding
    typedef enum logic [2:0] {
        SHAPE_I,
        SHAPE_O,
        SHAPE_T,
        SHAPE_S,
        SHAPE_Z,
        SHAPE_J,
        SHAPE_L
    } shape_t;

endpackage

/* design/piece_if.sv */
`timescale 1ns/1ps

// Active piece link between the game controller and the drop unit
interface piece_if;

    logic                   load;        // One-cycle capture strobe
    tetris_grid_pkg::grid_t spawn_piece; // Piece to capture on load
    tetris_grid_pkg::grid_t stored;      // Permanent grid, level
    logic                   step;        // Drop tick, only while FALLING
    tetris_grid_pkg::grid_t piece;       // Current piece position
    logic                   landed;      // Pulse, step was blocked

    modport controller (
        output load,
        output spawn_piece,
        output stored,
        output step,
        input  piece,
        input  landed
    );

    modport drop (
        input  load,
        input  spawn_piece,
        input  stored,
        input  step,
        output piece,
        output landed
    );

endinterface

/* design/shape_counter.sv */
`timescale 1ns/1ps
`include "tetris_macros.svh"

// Deterministic piece order I O T S Z J L, repeating
module shape_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    advance, // One pulse per spawn
    output tetris_ctrl_pkg::shape_t shape
);

    logic last_shape; // Current shape is the end of the rotation

    assign last_shape = (shape == tetris_ctrl_pkg::shape_t'(`TETRIS_SHAPES - 1));

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            shape <= tetris_ctrl_pkg::SHAPE_I;
        end else if (advance) begin
            if (last_shape) begin
                shape <= tetris_ctrl_pkg::SHAPE_I; // Wrap L back to I
            end else begin
                shape <= tetris_ctrl_pkg::shape_t'(shape + 3'd1);
            end
        end
    end

endmodule

/* design/block_gen.sv */
`timescale 1ns/1ps
`include "tetris_macros.svh"

// Spawn bitmap generator
// Each shape fits a 4x2 box in rows 0 and 1, starting at the spawn column
module block_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,    // High for the SPAWN cycle
    input  tetris_ctrl_pkg::shape_t shape,
    output tetris_grid_pkg::grid_t  new_block
);

    logic [3:0]             top_pat; // Bit i is column SPAWN_COL + i
    logic [3:0]             bot_pat;
    tetris_grid_pkg::grid_t spawn_grid;

    always_comb begin
        case (shape)
            tetris_ctrl_pkg::SHAPE_I: begin
                top_pat = 4'b1111;
                bot_pat = 4'b0000;
            end
            tetris_ctrl_pkg::SHAPE_O: begin
                top_pat = 4'b0110;
                bot_pat = 4'b0110;
            end
            tetris_ctrl_pkg::SHAPE_T: begin
                top_pat = 4'b0111;
                bot_pat = 4'b0010; // Stem under the middle
            end
            tetris_ctrl_pkg::SHAPE_S: begin
                top_pat = 4'b0110;
                bot_pat = 4'b0011;
            end
            tetris_ctrl_pkg::SHAPE_Z: begin
                top_pat = 4'b0011;
                bot_pat = 4'b0110;
            end
            tetris_ctrl_pkg::SHAPE_J: begin
                top_pat = 4'b0111;
                bot_pat = 4'b0100; // Hook on the right
            end
            tetris_ctrl_pkg::SHAPE_L: begin
                top_pat = 4'b0111;
                bot_pat = 4'b0001; // Hook on the left
            end
            default: begin
                top_pat = 4'b0000;
                bot_pat = 4'b0000;
            end
        endcase
    end

    // Place the box in the two top rows, everything else empty
    always_comb begin
        spawn_grid    = '0;
        spawn_grid[0] = tetris_grid_pkg::row_t'(top_pat) << `TETRIS_SPAWN_COL;
        spawn_grid[1] = tetris_grid_pkg::row_t'(bot_pat) << `TETRIS_SPAWN_COL;
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            new_block <= '0;
        end else if (enable) begin
            new_block <= spawn_grid; // Held until the next spawn
        end
    end

endmodule

/* design/drop_unit.sv */
`timescale 1ns/1ps
`include "tetris_macros.svh"

// Active piece register with gravity
// A step either moves the piece one row down or, when blocked, flags a landing
module drop_unit (
    input logic  clk,
    input logic  reset,
    piece_if.drop pif
);

    tetris_grid_pkg::grid_t shifted;  // Piece one row lower
    logic                   on_floor; // Piece touches the bottom row
    logic                   hits_stack;
    logic                   can_move;

    // Row r moves to row r+1, an empty row enters at the top
    assign shifted = {pif.piece[`TETRIS_ROWS-2:0], tetris_grid_pkg::row_t'(0)};

    assign on_floor   = |pif.piece[`TETRIS_ROWS-1];
    assign hits_stack = |(shifted & pif.stored);
    assign can_move   = !on_floor && !hits_stack;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pif.piece  <= '0;
            pif.landed <= 1'b0;
        end else begin
            pif.landed <= 1'b0; // Pulse only
            if (pif.load) begin
                pif.piece <= pif.spawn_piece;
            end else if (pif.step) begin
                if (can_move) begin
                    pif.piece <= shifted;
                end else begin
                    pif.landed <= 1'b1; // Piece stays put, controller merges it
                end
            end
        end
    end

endmodule

/* design/game_fsm.sv */
`timescale 1ns/1ps

// Game controller
// Sequences spawn, fall and merge, keeps the stored grid and builds the display
module game_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    drop_tick,    // One-cycle gravity strobe
    input  tetris_ctrl_pkg::shape_t shape,        // Shape about to spawn
    input  tetris_grid_pkg::grid_t  new_block,    // Registered spawn bitmap
    output logic                    spawn_enable, // To block_gen
    output logic                    advance,      // To shape_counter
    output tetris_grid_pkg::grid_t  display,
    output logic                    finish,       // Top-out, sticky
    piece_if.controller             pif
);

    tetris_ctrl_pkg::game_state_t state;
    tetris_ctrl_pkg::game_state_t next_state;

    tetris_grid_pkg::grid_t  stored;      // Permanent blocks
    logic                    armed;       // Set one clock after reset release
    logic                    spawn_go;    // The single real SPAWN cycle
    logic                    top_out;     // Spawn box collides with stack

    // Holds off the first spawn until the clock after reset release
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    assign spawn_go = (state == tetris_ctrl_pkg::SPAWN) && armed;

    // Spawn bitmap only fills rows 0 and 1, so the whole grid compare covers the spawn box
    assign top_out = |(new_block & stored);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= tetris_ctrl_pkg::SPAWN;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            tetris_ctrl_pkg::SPAWN: begin
                if (spawn_go) begin
                    next_state = tetris_ctrl_pkg::SPAWN_WAIT;
                end
            end
            tetris_ctrl_pkg::SPAWN_WAIT: begin
                next_state = top_out ? tetris_ctrl_pkg::GAME_OVER : tetris_ctrl_pkg::FALLING;
            end
            tetris_ctrl_pkg::FALLING: begin
                if (pif.landed) begin
                    next_state = tetris_ctrl_pkg::LANDED;
                end
            end
            tetris_ctrl_pkg::LANDED:    next_state = tetris_ctrl_pkg::SPAWN; // No back-pressure
            tetris_ctrl_pkg::GAME_OVER: next_state = tetris_ctrl_pkg::GAME_OVER;
            default:                    next_state = tetris_ctrl_pkg::SPAWN;
        endcase
    end

    // Merge the resting piece, once per landing
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stored <= '0;
        end else if (state == tetris_ctrl_pkg::LANDED) begin
            stored <= stored | pif.piece;
        end
    end

    assign spawn_enable = spawn_go;
    assign advance      = spawn_go; // Counter moves on past the shape just drawn
    assign finish       = (state == tetris_ctrl_pkg::GAME_OVER);

    assign pif.load        = (state == tetris_ctrl_pkg::SPAWN_WAIT) && !top_out;
    assign pif.spawn_piece = new_block;
    assign pif.stored      = stored;
    assign pif.step        = drop_tick && (state == tetris_ctrl_pkg::FALLING);

    // Overlay picked by state
    always_comb begin
        case (state)
            tetris_ctrl_pkg::FALLING: display = pif.piece | stored;
            tetris_ctrl_pkg::LANDED:  display = stored; // Before the merge edge
            default:                  display = new_block | stored;
        endcase
    end

endmodule

/* design/tetris_core.sv */
`timescale 1ns/1ps

// Falling-block puzzle core, top level
module tetris_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   drop_tick,
    output logic                   spawn_enable,
    output tetris_grid_pkg::grid_t display,
    output logic                   finish
);

    tetris_ctrl_pkg::shape_t shape;     // Next shape in rotation
    tetris_grid_pkg::grid_t  new_block; // Spawn bitmap
    logic                    advance;

    piece_if pif ();

    shape_counter shape_counter_inst (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .shape   (shape)
    );

    block_gen block_gen_inst (
        .clk       (clk),
        .reset     (reset),
        .enable    (spawn_enable),
        .shape     (shape),
        .new_block (new_block)
    );

    drop_unit drop_unit_inst (
        .clk   (clk),
        .reset (reset),
        .pif   (pif.drop)
    );

    game_fsm game_fsm_inst (
        .clk          (clk),
        .reset        (reset),
        .drop_tick    (drop_tick),
        .shape        (shape),
        .new_block    (new_block),
        .spawn_enable (spawn_enable),
        .advance      (advance),
        .display      (display),
        .finish       (finish),
        .pif          (pif.controller)
    );

endmodule

/* bench/tetris_core_tb.sv */
`timescale 1ns/1ps
`include "tetris_macros.svh"

// Drives a full game from reset to top-out and checks the display against a model
module tetris_core_tb;

    localparam int CLK_PERIOD       = 20;
    localparam int DRIVE_DELAY      = 2;  // Inputs change this long after the rising edge
    localparam int RESET_CYCLES     = 16;
    localparam int RAND_SEED        = 74875;
    localparam int NUM_PIECES       = 14;
    localparam int MAX_TICKS        = 22; // Full drop from spawn to floor plus the landing tick
    localparam int TICK_CYCLES      = 7;  // Longest idle gap plus the tick itself
    localparam int SPAWN_CYCLES     = 8;  // Landing, merge and spawn overhead per piece
    localparam int GAME_OVER_CYCLES = 24;
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + GAME_OVER_CYCLES
                                    + NUM_PIECES * (MAX_TICKS * TICK_CYCLES + SPAWN_CYCLES);

    // One stimulus row per piece
    typedef struct packed {
        tetris_ctrl_pkg::shape_t shape;   // Shape expected in the rotation
        logic                    top_out; // This spawn must overlap the stack
    } piece_row_t;

    logic                   clk;
    logic                   reset;
    logic                   drop_tick;
    logic                   spawn_enable;
    tetris_grid_pkg::grid_t display;
    logic                   finish;

    piece_row_t             piece_table [NUM_PIECES];
    tetris_grid_pkg::grid_t model_stored; // Reference copy of the permanent grid
    tetris_grid_pkg::grid_t model_piece;  // Reference copy of the falling piece
    tetris_grid_pkg::grid_t last_spawn;   // Bitmap block_gen still holds

    tetris_core tetris_core_inst (
        .clk          (clk),
        .reset        (reset),
        .drop_tick    (drop_tick),
        .spawn_enable (spawn_enable),
        .display      (display),
        .finish       (finish)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_grid(string name, tetris_grid_pkg::grid_t got,
                              tetris_grid_pkg::grid_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR %s at %0t: got %h expected %h", name, $time, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR %s at %0t: got %h expected %h", name, $time, got, exp));
        end
    endtask

    // Step to the drive point of the next cycle, outputs are settled there
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // Row with columns lo to hi set
    function automatic tetris_grid_pkg::row_t row_span(int lo, int hi);
        tetris_grid_pkg::row_t r;
        int                    c;
        r = '0;
        for (c = lo; c <= hi; c++) begin
            r = r | (tetris_grid_pkg::row_t'(1) << c);
        end
        return r;
    endfunction

    // Spawn pictures in the top two rows
    function automatic tetris_grid_pkg::grid_t shape_bitmap(tetris_ctrl_pkg::shape_t s);
        tetris_grid_pkg::grid_t g;
        g = '0;
        case (s)
            tetris_ctrl_pkg::SHAPE_I: g[0] = row_span(3, 6);
            tetris_ctrl_pkg::SHAPE_O: begin
                g[0] = row_span(4, 5);
                g[1] = row_span(4, 5);
            end
            tetris_ctrl_pkg::SHAPE_T: begin
                g[0] = row_span(3, 5);
                g[1] = row_span(4, 4);
            end
            tetris_ctrl_pkg::SHAPE_S: begin
                g[0] = row_span(4, 5);
                g[1] = row_span(3, 4);
            end
            tetris_ctrl_pkg::SHAPE_Z: begin
                g[0] = row_span(3, 4);
                g[1] = row_span(4, 5);
            end
            tetris_ctrl_pkg::SHAPE_J: begin
                g[0] = row_span(3, 5);
                g[1] = row_span(5, 5);
            end
            tetris_ctrl_pkg::SHAPE_L: begin
                g[0] = row_span(3, 5);
                g[1] = row_span(3, 3);
            end
            default: g = '0;
        endcase
        return g;
    endfunction

    // Two rounds of the rotation, the 14th spawn hits the stack in the spawn rows
    task automatic load_table();
        piece_table[0]  = '{tetris_ctrl_pkg::SHAPE_I, 1'b0};
        piece_table[1]  = '{tetris_ctrl_pkg::SHAPE_O, 1'b0};
        piece_table[2]  = '{tetris_ctrl_pkg::SHAPE_T, 1'b0};
        piece_table[3]  = '{tetris_ctrl_pkg::SHAPE_S, 1'b0};
        piece_table[4]  = '{tetris_ctrl_pkg::SHAPE_Z, 1'b0};
        piece_table[5]  = '{tetris_ctrl_pkg::SHAPE_J, 1'b0};
        piece_table[6]  = '{tetris_ctrl_pkg::SHAPE_L, 1'b0};
        piece_table[7]  = '{tetris_ctrl_pkg::SHAPE_I, 1'b0};
        piece_table[8]  = '{tetris_ctrl_pkg::SHAPE_O, 1'b0};
        piece_table[9]  = '{tetris_ctrl_pkg::SHAPE_T, 1'b0};
        piece_table[10] = '{tetris_ctrl_pkg::SHAPE_S, 1'b0};
        piece_table[11] = '{tetris_ctrl_pkg::SHAPE_Z, 1'b0};
        piece_table[12] = '{tetris_ctrl_pkg::SHAPE_J, 1'b0}; // Lands without moving
        piece_table[13] = '{tetris_ctrl_pkg::SHAPE_L, 1'b1};
    endtask

    // Tick the model piece down until a step is blocked, then wait for the next spawn
    task automatic fall_piece();
        int                     gap;
        int                     waited;
        logic                   blocked;
        tetris_grid_pkg::grid_t lower;

        blocked = 1'b0;
        while (!blocked) begin
            gap = $urandom_range(6, 1);
            repeat (gap) begin
                next_cycle();
                check_bit("spawn_enable", spawn_enable, 1'b0);
                check_grid("display", display, model_stored | model_piece);
            end
            lower   = model_piece << `TETRIS_COLS; // One row further from the top
            blocked = (model_piece[`TETRIS_ROWS-1] != '0) || ((lower & model_stored) != '0);
            drop_tick = 1'b1;
            next_cycle();
            drop_tick = 1'b0;
            if (!blocked) begin
                model_piece = lower;
            end
            check_grid("display", display, model_stored | model_piece); // Blocked stays put
        end
        model_stored = model_stored | model_piece;
        for (waited = 0; waited < 3 && spawn_enable !== 1'b1; waited++) begin
            next_cycle();
        end
        if (spawn_enable !== 1'b1) begin
            fail_run("spawn_enable did not rise within three cycles of a landing");
        end
    endtask

    // Top-out reached, everything must freeze whatever the ticks do
    task automatic hold_game_over(tetris_grid_pkg::grid_t frozen);
        int n;
        check_bit("finish", finish, 1'b1);
        check_bit("spawn_enable", spawn_enable, 1'b0);
        check_grid("display", display, frozen);
        for (n = 0; n < GAME_OVER_CYCLES; n++) begin
            drop_tick = (($urandom % 3) != 0);
            next_cycle();
            check_bit("finish", finish, 1'b1);
            check_bit("spawn_enable", spawn_enable, 1'b0);
            check_grid("display", display, frozen);
        end
        drop_tick = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before the game reached top-out");
    end

    initial begin
        int                     idx;
        int                     waited;
        logic                   over;
        logic                   model_top;
        tetris_grid_pkg::grid_t bitmap;

        void'($urandom(RAND_SEED));
        reset        = 1'b1;
        drop_tick    = 1'b0;
        model_stored = '0;
        model_piece  = '0;
        last_spawn   = '0;
        over         = 1'b0;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        check_grid("display", display, '0);
        check_bit("finish", finish, 1'b0);
        check_bit("spawn_enable", spawn_enable, 1'b0);

        for (waited = 0; waited < 4 && spawn_enable !== 1'b1; waited++) begin
            next_cycle();
        end
        if (spawn_enable !== 1'b1) begin
            fail_run("spawn_enable never rose after reset release");
        end

        for (idx = 0; idx < NUM_PIECES && !over; idx++) begin
            // SPAWN cycle, block_gen still shows the previous bitmap
            check_bit("finish", finish, 1'b0);
            check_grid("display", display, model_stored | last_spawn);
            drop_tick = 1'b1; // Stray tick outside FALLING
            next_cycle();

            // SPAWN_WAIT with the new bitmap
            bitmap = shape_bitmap(piece_table[idx].shape);
            check_bit("spawn_enable", spawn_enable, 1'b0);
            check_bit("finish", finish, 1'b0);
            check_grid("display", display, model_stored | bitmap);
            model_top = ((bitmap & model_stored) != '0);
            if (model_top !== piece_table[idx].top_out) begin
                fail_run($sformatf("piece %0d top-out in the model does not match the table",
                                   idx));
            end
            next_cycle();
            drop_tick  = 1'b0;
            last_spawn = bitmap;

            if (model_top) begin
                hold_game_over(model_stored | bitmap);
                over = 1'b1;
            end else begin
                check_bit("finish", finish, 1'b0);
                check_grid("display", display, model_stored | bitmap); // Ticks had no effect
                model_piece = bitmap;
                fall_piece();
            end
        end

        if (over) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_run("all pieces played without the expected top-out");
        end
    end

endmodule

/* tb.f */
+incdir+design
design/tetris_grid_pkg.sv
design/tetris_ctrl_pkg.sv
design/piece_if.sv
design/shape_counter.sv
design/block_gen.sv
design/drop_unit.sv
design/game_fsm.sv
design/tetris_core.sv
bench/tetris_core_tb.sv

/* Makefile */
TOP = tetris_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
